// ==== hyperram_macros.svh ====
`ifndef HYPERRAM_MACROS_SVH
`define HYPERRAM_MACROS_SVH

// Device size as log2 of the number of 32-bit words.
// Word address bits above this width alias onto the array.
`define HR_MEM_WORD_BITS 10

// Initial latency in clock periods. One period is two bus bytes.
`define HR_LATENCY 6

// Set to 1 when the device requests double initial latency.
`define HR_LATENCY_2X 1

// Latency in bus bytes as seen by both ends of the bus
`define HR_LAT_BYTES_1X ((`HR_LATENCY) * 2)
`define HR_LAT_BYTES_2X ((`HR_LATENCY) * 4)

// APB register offsets.
`define HR_REG_CTRL   8'h00
`define HR_REG_ADDR   8'h04
`define HR_REG_WDATA  8'h08
`define HR_REG_RDATA  8'h0C
`define HR_REG_STATUS 8'h10

// CTRL register fields.
`define HR_CTRL_START 0
`define HR_CTRL_READ  1

`endif

// ==== hyperram_pkg.sv ====
`default_nettype none

package hyperram_pkg;

    typedef logic [31:0] hr_addr_t; // Word address.
    typedef logic [31:0] hr_data_t;
    typedef logic [3:0]  hr_mask_t; // Bit 3 enables data bits 31:24.
    typedef logic [5:0]  hr_lat_t;

    // Command from the register block to the bus master.
    typedef struct packed {
        logic     start;
        logic     read;
        hr_addr_t addr;
        hr_data_t wdata;
        hr_mask_t mask;
    } hr_cmd_t;

    typedef struct packed {
        logic     done;
        hr_data_t rdata;
    } hr_done_t;

    // Master to device half of the bus.
    typedef struct packed {
        logic       cs_n;
        logic [7:0] dq;
        logic       dq_valid;
        logic       rwds_mask; // High skips the write byte.
    } hbus_req_t;

    // Device to master half of the bus.
    typedef struct packed {
        logic [7:0] dq;
        logic       dq_valid;
        logic       rwds_lat;
    } hbus_rsp_t;

    // States of the bus master and of the device model.
    typedef enum logic [2:0] {
        HBM_IDLE, HBM_CA, HBM_LATENCY, HBM_WRITE, HBM_READ, HBM_END
    } hbm_state_t;

    typedef enum logic [2:0] {
        HRD_CA, HRD_WAIT, HRD_READ, HRD_WRITE, HRD_HOLD
    } hrd_state_t;

endpackage

`default_nettype wire

// ==== hyperram_apb_regs.sv ====
`default_nettype none

`include "hyperram_macros.svh"

module hyperram_apb_regs (
    input  wire                           clk,
    input  wire                           rst_n,
    input  wire                           psel,
    input  wire                           penable,
    input  wire                           pwrite,
    input  wire [7:0]                     paddr,
    input  wire hyperram_pkg::hr_data_t   pwdata,
    input  wire hyperram_pkg::hr_done_t   done,
    output hyperram_pkg::hr_data_t        prdata,
    output logic                          pready,
    output logic                          pslverr,
    output hyperram_pkg::hr_cmd_t         cmd
);

    hyperram_pkg::hr_addr_t addr_q;
    hyperram_pkg::hr_data_t wdata_q;
    hyperram_pkg::hr_data_t rdata_q;
    hyperram_pkg::hr_mask_t mask_q;
    logic                   read_q;
    logic                   start_q;
    logic                   busy_q;
    logic                   done_q;
    logic                   xfer_read_q; // Direction of the transaction in flight.

    logic access;
    logic addr_ok;
    logic start_req;
    logic refuse;
    logic wr_en;

    assign access = psel && penable;

    // A start pulse already issued counts as busy, so back-to-back starts are refused.
    assign refuse    = busy_q || start_q;
    assign start_req = access && pwrite && (paddr == `HR_REG_CTRL) && pwdata[`HR_CTRL_START];
    assign wr_en     = access && pwrite && addr_ok && !(start_req && refuse);

    assign pready  = 1'b1;
    assign pslverr = access && (!addr_ok || (start_req && refuse));

    assign cmd = '{
        start: start_q,
        read:  read_q,
        addr:  addr_q,
        wdata: wdata_q,
        mask:  mask_q
    };

    always_comb begin
        addr_ok = 1'b1;
        case (paddr)
            `HR_REG_CTRL:   prdata = {24'h0, mask_q, 2'b00, read_q, 1'b0};
            `HR_REG_ADDR:   prdata = addr_q;
            `HR_REG_WDATA:  prdata = wdata_q;
            `HR_REG_RDATA:  prdata = rdata_q;
            `HR_REG_STATUS: prdata = {30'h0, done_q, busy_q};
            default: begin
                prdata  = '0;
                addr_ok = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            addr_q      <= '0;
            wdata_q     <= '0;
            rdata_q     <= '0;
            mask_q      <= '0;
            read_q      <= 1'b0;
            start_q     <= 1'b0;
            busy_q      <= 1'b0;
            done_q      <= 1'b0;
            xfer_read_q <= 1'b0;
        end else begin
            start_q <= 1'b0;

            if (wr_en) begin
                case (paddr)
                    `HR_REG_CTRL: begin
                        read_q  <= pwdata[`HR_CTRL_READ];
                        mask_q  <= pwdata[7:4];
                        start_q <= pwdata[`HR_CTRL_START];
                    end
                    `HR_REG_ADDR:  addr_q  <= pwdata;
                    `HR_REG_WDATA: wdata_q <= pwdata;
                    default: ; // RDATA and STATUS ignore writes.
                endcase
            end

            if (start_q) begin
                busy_q      <= 1'b1;
                done_q      <= 1'b0;
                xfer_read_q <= read_q;
            end

            if (done.done) begin
                busy_q <= 1'b0;
                done_q <= 1'b1; // Sticky until the next start.
                if (xfer_read_q)
                    rdata_q <= done.rdata;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hyperbus_master.sv ====
`default_nettype none

`include "hyperram_macros.svh"

module hyperbus_master (
    input  wire                            clk,
    input  wire                            rst_n,
    input  wire hyperram_pkg::hr_cmd_t     cmd,
    input  wire hyperram_pkg::hbus_rsp_t   rsp,
    output hyperram_pkg::hr_done_t         done,
    output hyperram_pkg::hbus_req_t        req
);

    hyperram_pkg::hbm_state_t state;
    hyperram_pkg::hr_lat_t    lat_cnt;
    hyperram_pkg::hr_data_t   wr_sr;
    hyperram_pkg::hr_data_t   rdata_q;
    hyperram_pkg::hr_mask_t   mask_sr;
    logic [2:0]               idx; // Byte index within the current phase.
    logic [47:0]              ca_sr;
    logic [47:0]              ca_bytes;
    logic                     is_read;

    // Six CA bytes, most significant byte goes out first.
    assign ca_bytes = {cmd.read, 3'b000, cmd.addr[31:28],
                       cmd.addr[27:4],
                       8'h00,
                       4'h0, cmd.addr[3:0]};

    assign done = '{
        done:  (state == hyperram_pkg::HBM_END),
        rdata: rdata_q
    };

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= hyperram_pkg::HBM_IDLE;
            lat_cnt <= '0;
            wr_sr   <= '0;
            rdata_q <= '0;
            mask_sr <= '0;
            idx     <= '0;
            ca_sr   <= '0;
            is_read <= 1'b0;
            req     <= '{cs_n: 1'b1, dq: 8'h00, dq_valid: 1'b0, rwds_mask: 1'b0};
        end else begin
            case (state)
                hyperram_pkg::HBM_IDLE: begin
                    if (cmd.start) begin
                        state    <= hyperram_pkg::HBM_CA;
                        idx      <= '0;
                        is_read  <= cmd.read;
                        wr_sr    <= cmd.wdata;
                        mask_sr  <= cmd.mask;
                        ca_sr    <= ca_bytes << 8;
                        req.cs_n <= 1'b0;
                        req.dq   <= ca_bytes[47:40];
                    end
                end

                hyperram_pkg::HBM_CA: begin
                    // The device shows its latency request alongside the first CA byte.
                    if (idx == 3'd0)
                        lat_cnt <= rsp.rwds_lat ? hyperram_pkg::hr_lat_t'(`HR_LAT_BYTES_2X)
                                                : hyperram_pkg::hr_lat_t'(`HR_LAT_BYTES_1X);
                    if (idx == 3'd5) begin
                        state  <= hyperram_pkg::HBM_LATENCY;
                        req.dq <= 8'h00;
                    end else begin
                        req.dq <= ca_sr[47:40];
                        ca_sr  <= ca_sr << 8;
                        idx    <= idx + 3'd1;
                    end
                end

                hyperram_pkg::HBM_LATENCY: begin
                    lat_cnt <= lat_cnt - hyperram_pkg::hr_lat_t'(1);
                    idx     <= '0;
                    if (lat_cnt == hyperram_pkg::hr_lat_t'(1)) begin
                        if (is_read) begin
                            state <= hyperram_pkg::HBM_READ;
                        end else begin
                            state         <= hyperram_pkg::HBM_WRITE;
                            req.dq        <= wr_sr[31:24];
                            req.dq_valid  <= 1'b1;
                            req.rwds_mask <= ~mask_sr[3];
                            wr_sr         <= wr_sr << 8;
                            mask_sr       <= mask_sr << 1;
                        end
                    end
                end

                hyperram_pkg::HBM_WRITE: begin
                    if (idx == 3'd3) begin
                        state         <= hyperram_pkg::HBM_END;
                        req.cs_n      <= 1'b1;
                        req.dq        <= 8'h00;
                        req.dq_valid  <= 1'b0;
                        req.rwds_mask <= 1'b0;
                    end else begin
                        req.dq        <= wr_sr[31:24];
                        req.rwds_mask <= ~mask_sr[3];
                        wr_sr         <= wr_sr << 8;
                        mask_sr       <= mask_sr << 1;
                        idx           <= idx + 3'd1;
                    end
                end

                hyperram_pkg::HBM_READ: begin
                    // Read bytes may arrive with gaps. Only strobed bytes count.
                    if (rsp.dq_valid) begin
                        rdata_q <= {rdata_q[23:0], rsp.dq};
                        idx     <= idx + 3'd1;
                        if (idx == 3'd3) begin
                            state    <= hyperram_pkg::HBM_END;
                            req.cs_n <= 1'b1;
                        end
                    end
                end

                hyperram_pkg::HBM_END: state <= hyperram_pkg::HBM_IDLE;

                default: state <= hyperram_pkg::HBM_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hyperram_device.sv ====
`default_nettype none

`include "hyperram_macros.svh"

module hyperram_device (
    input  wire                            clk,
    input  wire                            rst_n,
    input  wire hyperram_pkg::hbus_req_t   req,
    output hyperram_pkg::hbus_rsp_t        rsp
);

    logic [7:0] mem [0:(4 << `HR_MEM_WORD_BITS)-1];

    hyperram_pkg::hrd_state_t state;
    hyperram_pkg::hr_lat_t    wait_cnt;
    hyperram_pkg::hr_addr_t   next_addr;
    logic [27:0]              ca_hi; // Word address bits 31:4 from CA bytes 0 to 3.
    logic [`HR_MEM_WORD_BITS+1:0] byte_addr;
    logic [2:0]               ca_cnt;
    logic [1:0]               xfer_cnt;
    logic                     is_read;
    logic                     rd_valid;
    logic [7:0]               rd_byte;
    logic                     rd_load;
    logic                     mem_we;
    logic                     last_wait;

    assign next_addr = {ca_hi, req.dq[3:0]};
    assign last_wait = (state == hyperram_pkg::HRD_WAIT) &&
                       (wait_cnt == hyperram_pkg::hr_lat_t'(1));

    // Fetch the next read byte one cycle before it goes on the bus.
    assign rd_load = !req.cs_n &&
                     ((last_wait && is_read) ||
                      (state == hyperram_pkg::HRD_READ && xfer_cnt != 2'd3));
    assign mem_we  = !req.cs_n && (state == hyperram_pkg::HRD_WRITE) &&
                     req.dq_valid && !req.rwds_mask;

    assign rsp = '{
        dq:       rd_byte,
        dq_valid: rd_valid,
        rwds_lat: !req.cs_n && (state == hyperram_pkg::HRD_CA) && (`HR_LATENCY_2X != 0)
    };

    always_ff @(posedge clk) begin
        if (mem_we)
            mem[byte_addr] <= req.dq;
        if (rd_load)
            rd_byte <= mem[byte_addr];
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= hyperram_pkg::HRD_CA;
            wait_cnt  <= '0;
            ca_hi     <= '0;
            byte_addr <= '0;
            ca_cnt    <= '0;
            xfer_cnt  <= '0;
            is_read   <= 1'b0;
            rd_valid  <= 1'b0;
        end else if (req.cs_n) begin
            state    <= hyperram_pkg::HRD_CA; // Deselect ends any transfer.
            ca_cnt   <= '0;
            rd_valid <= 1'b0;
        end else begin
            case (state)
                hyperram_pkg::HRD_CA: begin
                    ca_cnt <= ca_cnt + 3'd1;
                    case (ca_cnt)
                        3'd0: begin
                            is_read      <= req.dq[7];
                            ca_hi[27:24] <= req.dq[3:0];
                        end
                        3'd1: ca_hi[23:16] <= req.dq;
                        3'd2: ca_hi[15:8]  <= req.dq;
                        3'd3: ca_hi[7:0]   <= req.dq;
                        3'd5: begin
                            byte_addr <= {next_addr[`HR_MEM_WORD_BITS-1:0], 2'b00};
                            wait_cnt  <= hyperram_pkg::hr_lat_t'(
                                (`HR_LATENCY_2X != 0) ? `HR_LAT_BYTES_2X : `HR_LAT_BYTES_1X);
                            state     <= hyperram_pkg::HRD_WAIT;
                        end
                        default: ; // Byte 4 is reserved.
                    endcase
                end

                hyperram_pkg::HRD_WAIT: begin
                    wait_cnt <= wait_cnt - hyperram_pkg::hr_lat_t'(1);
                    xfer_cnt <= '0;
                    if (last_wait) begin
                        if (is_read) begin
                            state     <= hyperram_pkg::HRD_READ;
                            rd_valid  <= 1'b1;
                            byte_addr <= byte_addr + 1'b1;
                        end else begin
                            state <= hyperram_pkg::HRD_WRITE;
                        end
                    end
                end

                hyperram_pkg::HRD_READ: begin
                    xfer_cnt <= xfer_cnt + 2'd1;
                    if (xfer_cnt == 2'd3) begin
                        rd_valid <= 1'b0;
                        state    <= hyperram_pkg::HRD_HOLD;
                    end else begin
                        byte_addr <= byte_addr + 1'b1;
                    end
                end

                hyperram_pkg::HRD_WRITE: begin
                    if (req.dq_valid) begin
                        byte_addr <= byte_addr + 1'b1; // Masked bytes still advance.
                        xfer_cnt  <= xfer_cnt + 2'd1;
                        if (xfer_cnt == 2'd3)
                            state <= hyperram_pkg::HRD_HOLD;
                    end
                end

                default: ; // HOLD waits for cs_n to rise.
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hyperram_subsystem.sv ====
`default_nettype none

module hyperram_subsystem (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire                          psel,
    input  wire                          penable,
    input  wire                          pwrite,
    input  wire [7:0]                    paddr,
    input  wire hyperram_pkg::hr_data_t  pwdata,
    output hyperram_pkg::hr_data_t       prdata,
    output logic                         pready,
    output logic                         pslverr
);

    hyperram_pkg::hr_cmd_t   cmd;
    hyperram_pkg::hr_done_t  done;
    hyperram_pkg::hbus_req_t req;
    hyperram_pkg::hbus_rsp_t rsp;

    hyperram_apb_regs hyperram_apb_regs_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .done    (done),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .cmd     (cmd)
    );

    hyperbus_master hyperbus_master_i (
        .clk   (clk),
        .rst_n (rst_n),
        .cmd   (cmd),
        .rsp   (rsp),
        .done  (done),
        .req   (req)
    );

    hyperram_device hyperram_device_i (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (req),
        .rsp   (rsp)
    );

endmodule

`default_nettype wire

// ==== tb_hyperram.sv ====
`default_nettype none

`include "hyperram_macros.svh"

module tb_hyperram;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD   = 4;
    localparam int NUM_RANDOM   = 200;
    localparam int NUM_XACTIONS = NUM_RANDOM + 16; // Directed transactions come on top.
    localparam int WORDS        = 1 << `HR_MEM_WORD_BITS;

    logic                   clk;
    logic                   rst_n;
    logic                   psel;
    logic                   penable;
    logic                   pwrite;
    logic [7:0]             paddr;
    hyperram_pkg::hr_data_t pwdata;
    hyperram_pkg::hr_data_t prdata;
    logic                   pready;
    logic                   pslverr;

    logic [31:0] ref_mem   [0:WORDS-1];
    logic [31:0] ref_known [0:WORDS-1]; // Bits written so far. The device array starts undefined.
    logic [31:0] rng;
    int          checks;
    int          errors;

    hyperram_subsystem hyperram_subsystem_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check_bits(input string name, input logic [31:0] exp,
                              input logic [31:0] act, input logic [31:0] care);
        checks++;
        assert ((act & care) === (exp & care)) else begin
            errors++;
            $display("[FAIL] %0t ns %s expected %h got %h", $time, name, exp & care, act & care);
        end
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    function automatic logic [31:0] byte_enables(input hyperram_pkg::hr_mask_t mask);
        return {{8{mask[3]}}, {8{mask[2]}}, {8{mask[1]}}, {8{mask[0]}}};
    endfunction

    // One setup and one access cycle. Outputs are sampled mid-cycle in the access phase.
    task automatic apb_access(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                              output logic [31:0] rdata, output logic err);
        @(posedge clk);
        psel   <= 1'b1;
        pwrite <= wr;
        paddr  <= addr;
        pwdata <= wdata;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        rdata = prdata;
        err   = pslverr;
        check_bits("pready", 32'h1, {31'h0, pready}, 32'h1);
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data, input logic exp_err);
        logic [31:0] unused_data;
        logic        err;
        apb_access(1'b1, addr, data, unused_data, err);
        check_bits("pslverr", {31'h0, exp_err}, {31'h0, err}, 32'h1);
    endtask

    task automatic apb_read(input logic [7:0] addr, input logic exp_err, output logic [31:0] data);
        logic err;
        apb_access(1'b0, addr, 32'h0, data, err);
        check_bits("pslverr", {31'h0, exp_err}, {31'h0, err}, 32'h1);
    endtask

    task automatic start_command(input logic rd, input hyperram_pkg::hr_addr_t addr,
                                 input hyperram_pkg::hr_data_t data,
                                 input hyperram_pkg::hr_mask_t mask, input logic exp_err);
        apb_write(`HR_REG_ADDR, addr, 1'b0);
        apb_write(`HR_REG_WDATA, data, 1'b0);
        apb_write(`HR_REG_CTRL, {24'h0, mask, 2'b00, rd, 1'b1}, exp_err);
    endtask

    task automatic wait_done();
        hyperram_pkg::hr_data_t status;
        status = '0;
        while (!status[1])
            apb_read(`HR_REG_STATUS, 1'b0, status);
        check_bits("status", 32'h2, status, '1); // Done set and busy already clear.
    endtask

    task automatic model_write(input hyperram_pkg::hr_addr_t addr,
                               input hyperram_pkg::hr_data_t data,
                               input hyperram_pkg::hr_mask_t mask);
        logic [31:0] be;
        logic [`HR_MEM_WORD_BITS-1:0] idx;
        be  = byte_enables(mask);
        idx = addr[`HR_MEM_WORD_BITS-1:0]; // Upper address bits alias.
        ref_mem[idx]   = (ref_mem[idx] & ~be) | (data & be);
        ref_known[idx] = ref_known[idx] | be;
    endtask

    task automatic write_word(input hyperram_pkg::hr_addr_t addr,
                              input hyperram_pkg::hr_data_t data,
                              input hyperram_pkg::hr_mask_t mask);
        start_command(1'b0, addr, data, mask, 1'b0);
        wait_done();
        model_write(addr, data, mask);
    endtask

    task automatic read_word(input hyperram_pkg::hr_addr_t addr);
        hyperram_pkg::hr_data_t rdata;
        logic [`HR_MEM_WORD_BITS-1:0] idx;
        idx = addr[`HR_MEM_WORD_BITS-1:0];
        start_command(1'b1, addr, 32'h0, 4'h0, 1'b0);
        wait_done();
        apb_read(`HR_REG_RDATA, 1'b0, rdata);
        check_bits("rdata", ref_mem[idx], rdata, ref_known[idx]);
    endtask

    initial begin
        hyperram_pkg::hr_data_t rd;
        hyperram_pkg::hr_addr_t addr;
        logic [31:0]            r;
        clk     = 1'b0;
        rst_n   = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = 8'h00;
        pwdata  = '0;
        checks  = 0;
        errors  = 0;
        rng     = 32'd11335;
        for (int i = 0; i < WORDS; i++) begin
            ref_mem[i]   = '0;
            ref_known[i] = '0;
        end
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;

        apb_read(`HR_REG_STATUS, 1'b0, rd);
        check_bits("status", 32'h0, rd, '1);
        apb_read(`HR_REG_RDATA, 1'b0, rd);
        check_bits("rdata", 32'h0, rd, '1);
        apb_read(`HR_REG_CTRL, 1'b0, rd);
        check_bits("ctrl", 32'h0, rd, '1);

        write_word(32'h0000_0010, 32'hA5A5_1234, 4'hF);
        read_word(32'h0000_0010);
        apb_read(`HR_REG_STATUS, 1'b0, rd);
        check_bits("status", 32'h2, rd, '1);

        write_word(32'h0000_0010, 32'h1122_3344, 4'b0101);
        read_word(32'h0000_0010);
        apb_read(`HR_REG_RDATA, 1'b0, rd);
        check_bits("rdata", 32'hA522_1244, rd, '1);

        // Sixteen word slots with random upper bits, so aliased addresses hit written words.
        for (int n = 0; n < NUM_RANDOM; n++) begin
            rng  = xorshift32(rng);
            r    = rng;
            rng  = xorshift32(rng);
            addr = (rng & ~((32'd1 << `HR_MEM_WORD_BITS) - 32'd1)) | (r & 32'h0000_000F);
            rng  = xorshift32(rng);
            if (r[31] && ref_known[addr[`HR_MEM_WORD_BITS-1:0]] != '0)
                read_word(addr);
            else
                write_word(addr, rng, r[11:8]);
        end

        apb_read(8'h14, 1'b1, rd);
        apb_write(8'h20, 32'hDEAD_BEEF, 1'b1);

        write_word(32'h0000_0030, 32'h0BAD_F00D, 4'hF);
        start_command(1'b0, 32'h0000_0020, 32'hCAFE_0001, 4'hF, 1'b0);
        model_write(32'h0000_0020, 32'hCAFE_0001, 4'hF);
        apb_read(`HR_REG_STATUS, 1'b0, rd);
        check_bits("status", 32'h1, rd, '1);
        start_command(1'b0, 32'h0000_0030, 32'h5555_AAAA, 4'hF, 1'b1); // Refused while busy.
        wait_done();
        read_word(32'h0000_0020);
        read_word(32'h0000_0030);

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

    initial begin
        #(NUM_XACTIONS * 200 * CLK_PERIOD);
        $display("Watchdog timeout, the DUT never finished all transactions.");
        $display("Checks: %0d, errors: %0d", checks, errors);
        $display("Some tests failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+.
hyperram_pkg.sv
hyperram_apb_regs.sv
hyperbus_master.sv
hyperram_device.sv
hyperram_subsystem.sv
tb_hyperram.sv

// ==== run.sh ====
#!/bin/sh
# Compile and run the HyperRAM testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module tb_hyperram -o tb_hyperram_sim
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/tb_hyperram_sim > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "All tests passed" "$LOG"; then
    exit 0
fi
exit 1
